//--- files.f
rtl/soc_pkg.sv
rtl/request_decode.sv
rtl/bram_word.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/response_mux.sv
rtl/soc_bus.sv
bench/tb_soc_bus.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - rtl/soc_pkg.sv
  - rtl/request_decode.sv
  - rtl/bram_word.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/response_mux.sv
  - rtl/soc_bus.sv
  - target: test
    files:
      - bench/tb_soc_bus.sv

//--- bench/tb_soc_bus.sv
/*
 * testbench for the peripheral fabric
 * directed bus, RAM, UART and fault tests against soc_bus
 */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus;
    import soc_pkg::*;

    localparam int TIMEOUT_CYCLES = 20_000;
    localparam int POLL_LIMIT     = 2 * CLKS_PER_BIT;

    // expected register values
    localparam byte_t EXP_LED_RESET = 8'hF9;
    localparam data_t EXP_CLK_HZ    = 32'd1_843_200;
    localparam data_t EXP_RX_EMPTY  = 32'hFFFF_FFFF;
    localparam int    RX_READY_BIT  = 8;
    localparam data_t TX_IDLE_MASK  = 32'h0000_6000;

    logic  clk;
    logic  resetn;
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    logic  rx_line;
    logic  ready;
    data_t rdata;
    logic  access_fault;
    logic  tx_line;
    byte_t led;

    int    seed;
    int    cycle_count = 0;
    data_t ram_model [BRAM_WORDS];

    soc_bus u_soc_bus (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .addr         (addr),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .uart_rx      (rx_line),
        .ready        (ready),
        .rdata        (rdata),
        .access_fault (access_fault),
        .uart_tx      (tx_line),
        .led          (led)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reporting

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run("check failed");
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests did not finish in time");
        end
    end

    // byte merge of a RAM word by write strobes
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t s);
        data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // bus master

    task automatic bus_access(input addr_t a, input data_t d, input strb_t s,
                              output data_t rd, output logic fault);
        // wait out a response still showing
        if (ready) begin
            @(posedge clk);
            #1;
        end
        check_value("ready before request", data_t'(ready), 32'd0);
        valid = 1'b1;
        addr  = a;
        wdata = d;
        wstrb = s;
        @(posedge clk);
        #1;
        // exactly one cycle after acceptance
        check_value("ready", data_t'(ready), 32'd1);
        rd    = rdata;
        fault = access_fault;
        valid = 1'b0;
        wstrb = '0;
    endtask

    task automatic bus_write(input addr_t a, input data_t d, input strb_t s,
                             output logic fault);
        data_t rd;
        bus_access(a, d, s, rd, fault);
    endtask

    task automatic bus_read(input addr_t a, output data_t rd, output logic fault);
        bus_access(a, '0, '0, rd, fault);
    endtask

    ////////////////////////////////////////////////////////////
    // uart line

    task automatic uart_send_frame(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
        end
    endtask

    task automatic uart_expect_frame(input byte_t exp);
        int waited;
        waited = 0;
        // tx only changes at clock edges
        while (tx_line === 1'b1) begin
            if (waited == POLL_LIMIT) begin
                abort_run("no start bit seen on uart_tx");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        #1;
        check_value("uart_tx start bit", data_t'(tx_line), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            #1;
            check_value($sformatf("uart_tx data bit %0d", i), data_t'(tx_line),
                        data_t'(exp[i]));
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
        check_value("uart_tx stop bit", data_t'(tx_line), 32'd1);
    endtask

    ////////////////////////////////////////////////////////////
    // tests

    task automatic led_freq_test();
        data_t d;
        data_t rd;
        logic  fault;
        check_value("led after reset", data_t'(led), data_t'(EXP_LED_RESET));
        d = $random(seed);
        bus_write(LED_ADDR, d, 4'hF, fault);
        check_value("led", data_t'(led), data_t'(d[7:0]));
        check_value("led write fault", data_t'(fault), 32'd0);
        bus_read(LED_ADDR, rd, fault);
        check_value("led read data", rd, 32'd0);
        check_value("led after read", data_t'(led), data_t'(d[7:0]));
        bus_read(CPU_FREQ_ADDR, rd, fault);
        check_value("cpu freq", rd, EXP_CLK_HZ);
        bus_write(CPU_FREQ_ADDR, 32'hDEAD_BEEF, 4'hF, fault);
        check_value("cpu freq write fault", data_t'(fault), 32'd0);
        bus_read(CPU_FREQ_ADDR, rd, fault);
        check_value("cpu freq after write", rd, EXP_CLK_HZ);
    endtask

    task automatic ram_test();
        bram_addr_t idx [16];
        data_t      d;
        data_t      rd;
        logic       fault;
        for (int i = 0; i < 16; i++) begin
            idx[i] = bram_addr_t'($random(seed));
            d      = $random(seed);
            bus_write(addr_t'({idx[i], 2'b00}), d, 4'hF, fault);
            check_value("ram write fault", data_t'(fault), 32'd0);
            ram_model[idx[i]] = d;
        end
        // partial strobes on two of the words
        d = $random(seed);
        bus_write(addr_t'({idx[3], 2'b00}), d, 4'b0101, fault);
        ram_model[idx[3]] = merge_bytes(ram_model[idx[3]], d, 4'b0101);
        d = $random(seed);
        bus_write(addr_t'({idx[10], 2'b00}), d, 4'b1000, fault);
        ram_model[idx[10]] = merge_bytes(ram_model[idx[10]], d, 4'b1000);
        for (int i = 0; i < 16; i++) begin
            bus_read(addr_t'({idx[i], 2'b00}), rd, fault);
            check_value($sformatf("ram word %0d", idx[i]), rd, ram_model[idx[i]]);
            check_value("ram read fault", data_t'(fault), 32'd0);
        end
    endtask

    task automatic transmit_test();
        byte_t b;
        data_t rd;
        logic  fault;
        int    polls;
        b = byte_t'($random(seed));
        bus_write(UART_DATA_ADDR, data_t'(b), 4'h1, fault);
        check_value("tx write fault", data_t'(fault), 32'd0);
        fork
            uart_expect_frame(b);
            begin
                bus_read(UART_LSR_ADDR, rd, fault);
                check_value("lsr idle bits while sending", rd & TX_IDLE_MASK, 32'd0);
            end
        join
        polls = 0;
        rd    = '0;
        while ((rd & TX_IDLE_MASK) != TX_IDLE_MASK) begin
            if (polls == POLL_LIMIT) begin
                abort_run("transmitter never returned to idle");
            end
            bus_read(UART_LSR_ADDR, rd, fault);
            polls++;
        end
    endtask

    task automatic receive_test();
        byte_t b;
        data_t rd;
        logic  fault;
        int    polls;
        bus_read(UART_DATA_ADDR, rd, fault);
        check_value("rx read while empty", rd, EXP_RX_EMPTY);
        bus_read(UART_LSR_ADDR, rd, fault);
        check_value("lsr rx ready before frame", data_t'(rd[RX_READY_BIT]), 32'd0);
        b = byte_t'($random(seed));
        uart_send_frame(b);
        polls = 0;
        rd    = '0;
        while (!rd[RX_READY_BIT]) begin
            if (polls == POLL_LIMIT) begin
                abort_run("received byte never showed in the line status");
            end
            bus_read(UART_LSR_ADDR, rd, fault);
            polls++;
        end
        bus_read(UART_DATA_ADDR, rd, fault);
        check_value("rx byte", rd, data_t'(b));
        check_value("rx read fault", data_t'(fault), 32'd0);
        // holding register now empty
        bus_read(UART_DATA_ADDR, rd, fault);
        check_value("rx read after pop", rd, EXP_RX_EMPTY);
    endtask

    task automatic fault_test();
        addr_t bad [3];
        data_t rd;
        logic  fault;
        int    ready_count;
        bad[0] = 32'h2000_0000;
        bad[1] = 32'h1000_0010;
        bad[2] = 32'h0000_1000;
        for (int i = 0; i < 3; i++) begin
            bus_read(bad[i], rd, fault);
            check_value("unmapped read data", rd, 32'd0);
            check_value("unmapped read fault", data_t'(fault), 32'd1);
            bus_access(bad[i], $random(seed), 4'hF, rd, fault);
            check_value("unmapped write data", rd, 32'd0);
            check_value("unmapped write fault", data_t'(fault), 32'd1);
        end
        // valid held through the response cycle
        ready_count = 0;
        @(posedge clk);
        #1;
        valid = 1'b1;
        addr  = bad[0];
        wstrb = '0;
        repeat (2) begin
            @(posedge clk);
            #1;
            if (ready) begin
                ready_count++;
            end
        end
        valid = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
            if (ready) begin
                ready_count++;
            end
        end
        check_value("ready pulses for held request", data_t'(ready_count), 32'd1);
    endtask

    ////////////////////////////////////////////////////////////
    initial begin
        seed    = 47;
        resetn  = 1'b0;
        valid   = 1'b0;
        addr    = '0;
        wdata   = '0;
        wstrb   = '0;
        rx_line = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_value("ready after reset", data_t'(ready), 32'd0);
        check_value("access_fault after reset", data_t'(access_fault), 32'd0);
        check_value("uart_tx after reset", data_t'(tx_line), 32'd1);
        led_freq_test();
        ram_test();
        transmit_test();
        receive_test();
        fault_test();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/soc_bus.sv
/*
 * peripheral fabric top
 * request decoder, block RAM, UART pair and response mux
 */
`timescale 1ns/1ns
`default_nettype none

module soc_bus (
    input  logic           clk,
    input  logic           resetn,
    input  logic           valid,
    input  soc_pkg::addr_t addr,
    input  soc_pkg::data_t wdata,
    input  soc_pkg::strb_t wstrb,
    input  logic           uart_rx,
    output logic           ready,
    output soc_pkg::data_t rdata,
    output logic           access_fault,
    output logic           uart_tx,
    output soc_pkg::byte_t led
);
    import soc_pkg::*;

    bram_addr_t bram_addr;
    strb_t      bram_wmask;
    data_t      bram_rdata;
    logic       tx_start;
    byte_t      tx_byte;
    logic       tx_busy;
    logic       rx_pop;
    logic       rx_valid;
    byte_t      rx_byte;
    data_t      rx_word;
    target_t    resp_target;

    ////////////////////////////////////////////////////////////
    // input side
    request_decode u_request_decode (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .addr        (addr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .bram_addr   (bram_addr),
        .bram_wmask  (bram_wmask),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte),
        .rx_pop      (rx_pop),
        .resp_target (resp_target),
        .rx_word     (rx_word),
        .led         (led)
    );

    ////////////////////////////////////////////////////////////
    // peripherals
    bram_word u_bram_word (
        .clk   (clk),
        .addr  (bram_addr),
        .wmask (bram_wmask),
        .wdata (wdata),
        .rdata (bram_rdata)
    );

    uart_tx u_uart_tx (
        .clk    (clk),
        .resetn (resetn),
        .start  (tx_start),
        .data   (tx_byte),
        .tx     (uart_tx),
        .busy   (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk    (clk),
        .resetn (resetn),
        .rx     (uart_rx),
        .pop    (rx_pop),
        .valid  (rx_valid),
        .data   (rx_byte)
    );

    ////////////////////////////////////////////////////////////
    // output side
    response_mux u_response_mux (
        .resp_target  (resp_target),
        .bram_rdata   (bram_rdata),
        .tx_busy      (tx_busy),
        .rx_valid     (rx_valid),
        .rx_word      (rx_word),
        .ready        (ready),
        .rdata        (rdata),
        .access_fault (access_fault)
    );

endmodule

`default_nettype wire

//--- rtl/response_mux.sv
/*
 * response multiplexer
 * ready, read data and access fault from the registered target
 */
`timescale 1ns/1ns
`default_nettype none

module response_mux (
    input  soc_pkg::target_t resp_target,
    input  soc_pkg::data_t   bram_rdata,
    input  logic             tx_busy,
    input  logic             rx_valid,
    input  soc_pkg::data_t   rx_word,
    output logic             ready,
    output soc_pkg::data_t   rdata,
    output logic             access_fault
);
    import soc_pkg::*;

    data_t lsr_word;

    assign ready        = (resp_target != NONE);
    assign access_fault = (resp_target == FAULT);

    // line status, rx ready and tx idle
    always_comb begin
        lsr_word                   = '0;
        lsr_word[LSR_RX_READY_BIT] = rx_valid;
        if (!tx_busy) begin
            lsr_word = lsr_word | LSR_TX_IDLE_BITS;
        end
    end

    ////////////////////////////////////////////////////////////
    always_comb begin
        case (resp_target)
            BRAM:    rdata = bram_rdata;
            FREQ:    rdata = data_t'(SYSTEM_CLK_HZ);
            LSR:     rdata = lsr_word;
            // captured before the pop landed
            RX:      rdata = rx_word;
            TX:      rdata = '0;
            LED:     rdata = '0;
            FAULT:   rdata = '0;
            default: rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
/*
 * UART receiver
 * mid-bit sampling into a one-byte holding register cleared by pop
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic           clk,
    input  logic           resetn,
    input  logic           rx,
    input  logic           pop,
    output logic           valid,
    output soc_pkg::byte_t data
);
    import soc_pkg::*;

    logic [1:0]  sync;
    logic        rx_prev;
    uart_state_t state;
    baud_cnt_t   baud_cnt;
    logic [2:0]  bit_idx;
    byte_t       shift;
    logic        half_done;
    logic        bit_done;
    logic        load;

    assign half_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    assign bit_done  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    // good frame only with a high stop bit
    assign load      = (state == STOP) && bit_done && sync[1];

    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync     <= 2'b11;
            rx_prev  <= 1'b1;
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid    <= 1'b0;
        end else begin
            sync     <= {sync[0], rx};
            rx_prev  <= sync[1];
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    // falling edge of start bit
                    if (rx_prev && !sync[1]) begin
                        state <= START;
                    end
                end
                START: begin
                    if (half_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // glitch, back to idle
                        state    <= sync[1] ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        state    <= IDLE;
                    end
                end
            endcase
            if (pop) begin
                valid <= 1'b0;
            end
            // new frame wins over a pop in the same cycle
            if (load) begin
                valid <= 1'b1;
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_done) begin
            shift <= {sync[1], shift[7:1]};
        end
        if (load) begin
            data <= shift;
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
/*
 * UART transmitter
 * start bit, eight data bits lsb first, stop bit
 */
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic           clk,
    input  logic           resetn,
    input  logic           start,
    input  soc_pkg::byte_t data,
    output logic           tx,
    output logic           busy
);
    import soc_pkg::*;

    uart_state_t state;
    baud_cnt_t   baud_cnt;
    logic [2:0]  bit_idx;
    byte_t       shift;
    logic        bit_done;

    assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    assign busy     = (state != IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else begin
            baud_cnt <= (state == IDLE || bit_done) ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    // start while busy never reaches here
                    if (start) begin
                        state <= START;
                        tx    <= 1'b0;
                    end
                end
                START: begin
                    if (bit_done) begin
                        state   <= DATA;
                        bit_idx <= '0;
                        tx      <= shift[0];
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx <= shift[0];
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // data shifter, next bit always at position zero
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            shift <= data;
        end else if (bit_done && (state == START || state == DATA)) begin
            shift <= shift >> 1;
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!resetn)
        state == IDLE |-> tx);

endmodule

`default_nettype wire

//--- rtl/bram_word.sv
/*
 * word-organized block RAM
 * per-byte write mask, registered read of the old word
 */
`timescale 1ns/1ns
`default_nettype none

module bram_word (
    input  logic                clk,
    input  soc_pkg::bram_addr_t addr,
    input  soc_pkg::strb_t      wmask,
    input  soc_pkg::data_t      wdata,
    output soc_pkg::data_t      rdata
);
    import soc_pkg::*;

    data_t mem [BRAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (wmask[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // read before write on the same word
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- rtl/request_decode.sv
/*
 * request decoder
 * maps each bus request to a target, pulses the peripheral strobes
 * and registers the response target, LED register and rx word
 */
`timescale 1ns/1ns
`default_nettype none

module request_decode (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  soc_pkg::addr_t      addr,
    input  soc_pkg::data_t      wdata,
    input  soc_pkg::strb_t      wstrb,
    input  logic                rx_valid,
    input  soc_pkg::byte_t      rx_byte,
    output soc_pkg::bram_addr_t bram_addr,
    output soc_pkg::strb_t      bram_wmask,
    output logic                tx_start,
    output soc_pkg::byte_t      tx_byte,
    output logic                rx_pop,
    output soc_pkg::target_t    resp_target,
    output soc_pkg::data_t      rx_word,
    output soc_pkg::byte_t      led
);
    import soc_pkg::*;

    logic    is_write;
    logic    accept;
    target_t target_sel;

    assign is_write = |wstrb;
    // response cycle blocks a second accept of a held request
    assign accept = valid && (resp_target == NONE);

    ////////////////////////////////////////////////////////////
    // address map
    always_comb begin
        if (addr < addr_t'(BRAM_WORDS * 4)) begin
            target_sel = BRAM;
        end else if (addr == UART_DATA_ADDR) begin
            target_sel = is_write ? TX : RX;
        end else if (addr == UART_LSR_ADDR) begin
            target_sel = LSR;
        end else if (addr == CPU_FREQ_ADDR) begin
            target_sel = FREQ;
        end else if (addr == LED_ADDR) begin
            target_sel = LED;
        end else begin
            target_sel = FAULT;
        end
    end

    // strobes, only in the accepting cycle
    assign bram_addr  = addr[2 +: $bits(bram_addr_t)];
    assign bram_wmask = (accept && target_sel == BRAM) ? wstrb : '0;
    assign tx_start   = accept && (target_sel == TX);
    assign tx_byte    = wdata[7:0];
    assign rx_pop     = accept && (target_sel == RX);

    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            resp_target <= NONE;
            led         <= LED_RESET;
        end else begin
            resp_target <= accept ? target_sel : NONE;
            if (accept && target_sel == LED && is_write) begin
                led <= wdata[7:0];
            end
        end
    end

    // rx byte taken at the same edge as the pop
    always_ff @(posedge clk) begin
        if (rx_pop) begin
            rx_word <= rx_valid ? data_t'(rx_byte) : RX_EMPTY_WORD;
        end
    end

    a_single_response: assert property (@(posedge clk) disable iff (!resetn)
        resp_target != NONE |=> resp_target == NONE);

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({|bram_wmask, tx_start, rx_pop}));

endmodule

`default_nettype wire

//--- rtl/soc_pkg.sv
/*
 * soc fabric package
 * address map, bus widths, UART timing and shared enums
 */
`default_nettype none

package soc_pkg;

    // bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;

    // block RAM, mapped from address zero
    localparam int BRAM_WORDS = 1024;
    typedef logic [$clog2(BRAM_WORDS)-1:0] bram_addr_t;

    ////////////////////////////////////////////////////////////
    // io map
    localparam addr_t UART_DATA_ADDR = 32'h1000_0000;
    localparam addr_t UART_LSR_ADDR  = 32'h1000_0005;
    localparam addr_t CPU_FREQ_ADDR  = 32'h1100_0000;
    localparam addr_t LED_ADDR       = 32'h1200_0000;

    // clock and baud
    localparam int SYSTEM_CLK_HZ = 1_843_200;
    localparam int BAUD_RATE     = 115_200;
    localparam int CLKS_PER_BIT  = SYSTEM_CLK_HZ / BAUD_RATE;
    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

    // register values
    localparam byte_t LED_RESET        = 8'hF9;
    localparam int    LSR_RX_READY_BIT = 8;
    // bits 13 and 14, both set while tx idle
    localparam data_t LSR_TX_IDLE_BITS = 32'h0000_6000;
    localparam data_t RX_EMPTY_WORD    = '1;

    ////////////////////////////////////////////////////////////
    // response targets
    typedef enum logic [2:0] {
        NONE,
        BRAM,
        FREQ,
        LED,
        LSR,
        RX,
        TX,
        FAULT
    } target_t;

    // shared by transmitter and receiver
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_t;

endpackage

`default_nettype wire
